// File: hw/cpu_ctrl_consts.svh
// CPU control path constants
`ifndef CPU_CTRL_CONSTS_SVH
`define CPU_CTRL_CONSTS_SVH

/////////////////////////////
// Widths and depths
/////////////////////////////
`define CPU_INSTR_W     16      // Instruction word
`define CPU_OPCODE_W    5       // Opcode field, bits 15:11
`define CPU_WAIT_W      11      // Wait field, bits 10:0
`define CPU_IMEM_DEPTH  64      // Program words
`define CPU_IMEM_AW     6
`define CPU_IQ_DEPTH    4       // Queue words

// Clock cycles per WAIT tick
// 1 ms at 100 MHz would be 100000
`define CPU_TICK_CYCLES 4

/////////////////////////////
// Opcodes
/////////////////////////////
`define CPU_OP_AND      5'd0
`define CPU_OP_OR       5'd1
`define CPU_OP_XOR      5'd2
`define CPU_OP_NOT      5'd3
`define CPU_OP_ADD      5'd4    // x selects immediate
`define CPU_OP_LSL      5'd5
`define CPU_OP_SR       5'd6    // LSR / ASR
`define CPU_OP_ROT      5'd7    // ROL / ROR
`define CPU_OP_MOV      5'd8    // x selects SWAP
`define CPU_OP_LDR      5'd9
`define CPU_OP_LDU      5'd10
`define CPU_OP_LDL      5'd11
`define CPU_OP_ST       5'd12
`define CPU_OP_J        5'd13   // x selects JI
`define CPU_OP_B        5'd14
`define CPU_OP_NOP      5'd15   // WAIT when wait field nonzero
`define CPU_OP_HALT     5'd31   // 16 to 30 go to the vector unit

`endif

// File: hw/cpu_ctrl_pkg.sv
// CPU control path types
`include "cpu_ctrl_consts.svh"

package cpu_ctrl_pkg;

    /////////////////////////////
    // Vector types
    /////////////////////////////

    // Opcode 15:11, x bit 10, wait field 10:0
    typedef logic [`CPU_INSTR_W-1:0]  instr_t;
    typedef logic [`CPU_OPCODE_W-1:0] opcode_t;
    typedef logic [`CPU_WAIT_W-1:0]   wait_t;      // Ticks to wait
    typedef logic [`CPU_IMEM_AW-1:0]  imem_addr_t;

    /////////////////////////////
    // Control unit FSM
    /////////////////////////////
    typedef enum logic [2:0] {
        CU_IDLE,    // Nothing in decode
        CU_EXEC,    // Current instruction issuing
        CU_WAIT,    // WAIT timer running
        CU_VPU,     // Vector unit busy
        CU_HALT     // Stopped until reset
    } cu_state_t;

endpackage

// File: hw/wait_timer.sv
// WAIT instruction timer
`timescale 1ns/1ps
`include "cpu_ctrl_consts.svh"

module wait_timer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load,
    input  cpu_ctrl_pkg::wait_t load_ticks,
    output logic                done
);
    import cpu_ctrl_pkg::*;

    localparam int PRE_W = $clog2(`CPU_TICK_CYCLES + 1);
    localparam logic [PRE_W-1:0] PRE_RELOAD = PRE_W'(`CPU_TICK_CYCLES - 1);

    logic [PRE_W-1:0] prescale;     // Cycles left in this tick
    wait_t            ticks;        // Ticks left
    logic             tick_end;

    assign tick_end = (prescale == '0);
    assign done     = (ticks == '0);

    /////////////////////////////
    // Prescaler
    /////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prescale <= PRE_RELOAD;
        end else if (load || (tick_end && !done)) begin
            prescale <= PRE_RELOAD;     // Every tick full length
        end else if (!done) begin
            prescale <= prescale - 1'b1;
        end
    end

    /////////////////////////////
    // Tick counter
    /////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ticks <= '0;
        end else if (load) begin
            ticks <= load_ticks;
        end else if (tick_end && !done) begin
            ticks <= ticks - 1'b1;
        end
    end

endmodule

// File: hw/instr_fetch.sv
// Instruction fetch stage
`timescale 1ns/1ps
`include "cpu_ctrl_consts.svh"

module instr_fetch (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     prog_we,
    input  cpu_ctrl_pkg::imem_addr_t prog_addr,
    input  cpu_ctrl_pkg::instr_t     prog_data,
    input  logic                     start,
    input  logic                     iq_full,
    output logic                     fetch_push,
    output cpu_ctrl_pkg::instr_t     fetch_instr,
    output logic                     fetch_busy
);
    import cpu_ctrl_pkg::*;

    instr_t     imem [`CPU_IMEM_DEPTH];     // Program memory
    imem_addr_t pc;
    logic       running;
    instr_t     rd_instr;                   // Word waiting for the queue
    logic       rd_valid;
    logic       rd_halt;
    logic       rd_en;

    /////////////////////////////
    // Program load port
    /////////////////////////////
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    /////////////////////////////
    // Fetch sequencing
    /////////////////////////////
    assign rd_halt = rd_valid &&
                     (rd_instr[`CPU_INSTR_W-1 -: `CPU_OPCODE_W] == `CPU_OP_HALT);

    assign fetch_push  = running && rd_valid && !iq_full;   // Held while queue full
    assign rd_en       = running && !rd_halt && (!rd_valid || fetch_push);
    assign fetch_instr = rd_instr;
    assign fetch_busy  = running;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running  <= 1'b0;
            rd_valid <= 1'b0;
            pc       <= '0;
        end else if (start) begin
            running  <= 1'b1;               // Memory read starts next cycle
            rd_valid <= 1'b0;
            pc       <= '0;
        end else if (running) begin
            if (fetch_push && rd_halt) begin
                // HALT is in the queue, nothing more to fetch
                running  <= 1'b0;
                rd_valid <= 1'b0;
            end else if (rd_en) begin
                rd_valid <= 1'b1;
                pc       <= pc + imem_addr_t'(1);   // Wraps at depth
            end
        end
    end

    // Read register
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_instr <= imem[pc];
        end
    end

    // Program is only loaded while fetch is idle
    assert property (@(posedge clk) disable iff (!rst_n) !(prog_we && fetch_busy))
        else $error("instr_fetch: program write while fetching");

endmodule

// File: hw/instr_queue.sv
// Instruction queue between fetch and decode
`timescale 1ns/1ps
`include "cpu_ctrl_consts.svh"

module instr_queue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  cpu_ctrl_pkg::instr_t push_instr,
    input  logic                 pop,
    output cpu_ctrl_pkg::instr_t head_instr,
    output logic                 full,
    output logic                 empty
);
    import cpu_ctrl_pkg::*;

    localparam int PTR_W = $clog2(`CPU_IQ_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    instr_t           mem [`CPU_IQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                // Occupancy
    logic             at_depth;

    assign at_depth   = (count == CNT_W'(`CPU_IQ_DEPTH));
    assign full       = at_depth && !pop;   // A pop frees a slot this cycle
    assign empty      = (count == '0);
    assign head_instr = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_instr;
        end
    end

    /////////////////////////////
    // Pointers and count
    /////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) (push && at_depth) |-> pop)
        else $error("instr_queue: push into full queue");

    assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
        else $error("instr_queue: pop from empty queue");

endmodule

// File: hw/control_unit.sv
// Decode stage and issue control
`timescale 1ns/1ps
`include "cpu_ctrl_consts.svh"

module control_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_ctrl_pkg::instr_t  iq_instr,
    input  logic                  iq_empty,
    input  logic                  vpu_rdy,
    output logic                  iq_pop,
    output logic                  issue,
    output cpu_ctrl_pkg::opcode_t issue_opcode,
    output logic                  alu_to_reg,
    output logic                  pcr_to_reg,
    output logic                  mem_to_reg,
    output logic                  reg_we_dst_0,
    output logic                  reg_we_dst_1,
    output logic                  reg_read_0,
    output logic                  reg_read_1,
    output logic                  mem_we,
    output logic                  mem_re,
    output logic                  add_immd,
    output logic                  jump_immd,
    output logic                  ldu,
    output logic                  ldl,
    output logic                  branch,
    output logic                  jump,
    output logic                  z_we,
    output logic                  n_we,
    output logic                  v_we,
    output logic                  vpu_start,
    output logic                  halt,
    output logic                  stall
);
    import cpu_ctrl_pkg::*;

    instr_t    cur_instr;           // Instruction in decode
    opcode_t   cur_op;
    logic      cur_x;
    wait_t     cur_wait;
    cu_state_t state;
    cu_state_t state_nxt;
    logic      is_wait;
    logic      is_vec;
    logic      is_halt;
    logic      ready;               // Can take a new instruction
    logic      timer_load;
    logic      timer_done;

    assign cur_op   = cur_instr[`CPU_INSTR_W-1 -: `CPU_OPCODE_W];
    assign cur_x    = cur_instr[`CPU_WAIT_W-1];
    assign cur_wait = cur_instr[`CPU_WAIT_W-1:0];

    assign is_wait = (cur_op == `CPU_OP_NOP) && (cur_wait != '0);  // Zero is plain NOP
    assign is_halt = (cur_op == `CPU_OP_HALT);
    assign is_vec  = cur_op[`CPU_OPCODE_W-1] && !is_halt;         // 16 to 30

    /////////////////////////////
    // Issue FSM
    /////////////////////////////
    always_comb begin
        case (state)
            CU_IDLE: ready = 1'b1;
            CU_EXEC: ready = !(is_wait || is_vec || is_halt);     // Back-to-back issue
            CU_WAIT: ready = timer_done;
            CU_VPU:  ready = vpu_rdy;
            default: ready = 1'b0;
        endcase
    end

    assign iq_pop = ready && !iq_empty;
    assign issue  = (state == CU_EXEC);

    always_comb begin
        state_nxt = state;
        if (iq_pop) begin
            state_nxt = CU_EXEC;
        end else if (ready) begin
            state_nxt = CU_IDLE;
        end else if (state == CU_EXEC) begin
            if (is_halt)     state_nxt = CU_HALT;
            else if (is_vec) state_nxt = CU_VPU;
            else             state_nxt = CU_WAIT;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) state <= CU_IDLE;
        else        state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (iq_pop) cur_instr <= iq_instr;  // Head taken on pop
    end

    // WAIT timer
    assign timer_load = issue && is_wait;

    wait_timer u_wait_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (timer_load),
        .load_ticks (cur_wait),
        .done       (timer_done)
    );

    assign halt         = (state == CU_HALT) || (issue && is_halt);
    assign stall        = (state == CU_WAIT) || (state == CU_HALT) ||
                          ((state == CU_VPU) && !vpu_rdy);
    assign issue_opcode = issue ? cur_op : '0;

    /////////////////////////////
    // Strobe decode
    /////////////////////////////
    always_comb begin
        {alu_to_reg, pcr_to_reg, mem_to_reg, reg_we_dst_0, reg_we_dst_1} = '0;
        {reg_read_0, reg_read_1, mem_we, mem_re, add_immd, jump_immd} = '0;
        {ldu, ldl, branch, jump, z_we, n_we, v_we, vpu_start} = '0;
        if (issue) begin
            case (cur_op)
                `CPU_OP_AND, `CPU_OP_OR, `CPU_OP_XOR, `CPU_OP_NOT: begin
                    reg_read_0   = 1'b1;
                    reg_read_1   = 1'b1;
                    alu_to_reg   = 1'b1;
                    reg_we_dst_0 = 1'b1;
                    z_we         = 1'b1;
                end
                `CPU_OP_ADD: begin
                    reg_read_0   = 1'b1;
                    reg_read_1   = !cur_x;  // Rt unless immediate
                    alu_to_reg   = 1'b1;
                    reg_we_dst_0 = 1'b1;
                    add_immd     = cur_x;
                    {z_we, n_we, v_we} = 3'b111;
                end
                `CPU_OP_LSL: begin
                    reg_read_0   = 1'b1;
                    alu_to_reg   = 1'b1;
                    reg_we_dst_0 = 1'b1;
                    z_we         = 1'b1;
                end
                `CPU_OP_SR, `CPU_OP_ROT: begin  // No flags
                    reg_read_0   = 1'b1;
                    alu_to_reg   = 1'b1;
                    reg_we_dst_0 = 1'b1;
                end
                `CPU_OP_MOV: begin
                    reg_read_0   = 1'b1;
                    reg_read_1   = !cur_x;
                    reg_we_dst_0 = 1'b1;
                    reg_we_dst_1 = cur_x;   // SWAP writes both
                end
                `CPU_OP_LDR: begin
                    reg_read_1   = 1'b1;
                    mem_re       = 1'b1;
                    mem_to_reg   = 1'b1;
                    reg_we_dst_0 = 1'b1;
                end
                `CPU_OP_LDU, `CPU_OP_LDL: begin
                    reg_read_0   = 1'b1;
                    reg_we_dst_0 = 1'b1;
                    ldu          = (cur_op == `CPU_OP_LDU);
                    ldl          = (cur_op == `CPU_OP_LDL);
                end
                `CPU_OP_ST: begin
                    reg_read_1 = 1'b1;
                    mem_we     = 1'b1;
                end
                `CPU_OP_J: begin
                    jump         = 1'b1;
                    reg_read_1   = !cur_x;
                    pcr_to_reg   = 1'b1;    // Return address
                    reg_we_dst_1 = 1'b1;
                    jump_immd    = cur_x;
                end
                `CPU_OP_B:                  branch = 1'b1;
                `CPU_OP_NOP, `CPU_OP_HALT:  ;   // Handled by the FSM
                default:                    vpu_start = 1'b1;
            endcase
        end
    end

    // Halt holds and blocks every later issue
    assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt && !issue)
        else $error("control_unit: issue after halt");

    // Vector start comes with an issue and the unit gets at least one busy cycle
    assert property (@(posedge clk) disable iff (!rst_n) vpu_start |-> issue ##1 !issue)
        else $error("control_unit: vpu_start outside a vector issue");

endmodule

// File: hw/cpu_ctrl_top.sv
// CPU instruction control path
`timescale 1ns/1ps

module cpu_ctrl_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     prog_we,
    input  cpu_ctrl_pkg::imem_addr_t prog_addr,
    input  cpu_ctrl_pkg::instr_t     prog_data,
    input  logic                     start,
    input  logic                     vpu_rdy,
    output logic                     issue,
    output cpu_ctrl_pkg::opcode_t    issue_opcode,
    output logic                     alu_to_reg,
    output logic                     pcr_to_reg,
    output logic                     mem_to_reg,
    output logic                     reg_we_dst_0,
    output logic                     reg_we_dst_1,
    output logic                     reg_read_0,
    output logic                     reg_read_1,
    output logic                     mem_we,
    output logic                     mem_re,
    output logic                     add_immd,
    output logic                     jump_immd,
    output logic                     ldu,
    output logic                     ldl,
    output logic                     branch,
    output logic                     jump,
    output logic                     z_we,
    output logic                     n_we,
    output logic                     v_we,
    output logic                     vpu_start,
    output logic                     halt,
    output logic                     stall,
    output logic                     fetch_busy
);
    import cpu_ctrl_pkg::*;

    instr_t fetch_instr;
    instr_t iq_instr;       // Queue head
    logic   fetch_push;
    logic   iq_full;
    logic   iq_empty;
    logic   iq_pop;

    // Fetch stage
    instr_fetch u_instr_fetch (
        .clk, .rst_n, .prog_we, .prog_addr, .prog_data, .start, .iq_full,
        .fetch_push, .fetch_instr, .fetch_busy
    );

    instr_queue u_instr_queue (
        .clk, .rst_n,
        .push       (fetch_push),
        .push_instr (fetch_instr),
        .pop        (iq_pop),
        .head_instr (iq_instr),
        .full       (iq_full),
        .empty      (iq_empty)
    );

    // Decode stage
    control_unit u_control_unit (
        .clk, .rst_n, .iq_instr, .iq_empty, .vpu_rdy, .iq_pop,
        .issue, .issue_opcode,
        .alu_to_reg, .pcr_to_reg, .mem_to_reg, .reg_we_dst_0, .reg_we_dst_1,
        .reg_read_0, .reg_read_1, .mem_we, .mem_re, .add_immd, .jump_immd,
        .ldu, .ldl, .branch, .jump, .z_we, .n_we, .v_we,
        .vpu_start, .halt, .stall
    );

endmodule

// File: dv/cpu_ctrl_checker.sv
// Decode reference checker
`timescale 1ns/1ps
`include "cpu_ctrl_consts.svh"

module cpu_ctrl_checker (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  issue,
    input cpu_ctrl_pkg::opcode_t issue_opcode,
    input logic [17:0]           strobes,      // Same order as the masks below
    input logic                  vpu_start,
    input logic                  halt,
    input logic                  stall,
    input logic                  vpu_rdy
);
    import cpu_ctrl_pkg::*;

    //////////////////////////////
    // Strobe masks
    //////////////////////////////
    localparam logic [17:0] ALU  = 18'd1 << 17;   // alu_to_reg
    localparam logic [17:0] PCR  = 18'd1 << 16;
    localparam logic [17:0] MTR  = 18'd1 << 15;   // mem_to_reg
    localparam logic [17:0] WE0  = 18'd1 << 14;
    localparam logic [17:0] WE1  = 18'd1 << 13;
    localparam logic [17:0] RR0  = 18'd1 << 12;
    localparam logic [17:0] RR1  = 18'd1 << 11;
    localparam logic [17:0] MWE  = 18'd1 << 10;
    localparam logic [17:0] MRE  = 18'd1 << 9;
    localparam logic [17:0] ADI  = 18'd1 << 8;    // add_immd
    localparam logic [17:0] JMI  = 18'd1 << 7;    // jump_immd
    localparam logic [17:0] LDU  = 18'd1 << 6;
    localparam logic [17:0] LDL  = 18'd1 << 5;
    localparam logic [17:0] BR   = 18'd1 << 4;
    localparam logic [17:0] JMP  = 18'd1 << 3;
    localparam logic [17:0] FLZ  = 18'd1 << 2;
    localparam logic [17:0] FLN  = 18'd1 << 1;
    localparam logic [17:0] FLV  = 18'd1;

    instr_t exp_q[$];           // Words still to issue, in program order
    string  test_name = "none";
    int     errors = 0;
    int     issues = 0;
    int     cycle = 0;
    logic   halted = 1'b0;
    logic   vec_pending = 1'b0; // Last issue went to the vector unit
    logic   rdy_seen = 1'b0;
    logic   wait_pending = 1'b0;
    int     wait_cycle;
    int     wait_len;           // Minimum gap in cycles

    // Reference strobe table
    function automatic logic [17:0] ref_strobes(instr_t w);
        logic x;
        x = w[10];
        case (w[15:11])
            `CPU_OP_AND, `CPU_OP_OR,
            `CPU_OP_XOR, `CPU_OP_NOT: return RR0 | RR1 | ALU | WE0 | FLZ;
            `CPU_OP_ADD: return x ? (RR0 | ALU | WE0 | ADI | FLZ | FLN | FLV)
                                  : (RR0 | RR1 | ALU | WE0 | FLZ | FLN | FLV);
            `CPU_OP_LSL: return RR0 | ALU | WE0 | FLZ;
            `CPU_OP_SR, `CPU_OP_ROT: return RR0 | ALU | WE0;
            `CPU_OP_MOV: return x ? (RR0 | WE0 | WE1) : (RR0 | RR1 | WE0);   // SWAP or MOV
            `CPU_OP_LDR: return RR1 | MRE | MTR | WE0;
            `CPU_OP_LDU: return RR0 | WE0 | LDU;
            `CPU_OP_LDL: return RR0 | WE0 | LDL;
            `CPU_OP_ST:  return RR1 | MWE;
            `CPU_OP_J:   return x ? (JMP | PCR | WE1 | JMI) : (JMP | RR1 | PCR | WE1);
            `CPU_OP_B:   return BR;
            default:     return '0;   // NOP, HALT and vector words
        endcase
    endfunction

    function automatic logic is_vector(instr_t w);
        return (w[15:11] >= 5'd16) && (w[15:11] <= 5'd30);
    endfunction

    task automatic note_failure(input string msg);
        errors++;
        $display("FAIL %s: %s", test_name, msg);
    endtask

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: %s expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    //////////////////////////////
    // Test bookkeeping
    //////////////////////////////
    task automatic begin_test(input string name);
        test_name = name;
        errors    = 0;
        issues    = 0;
        exp_q.delete();
    endtask

    task automatic expect_word(input instr_t w);
        exp_q.push_back(w);
    endtask

    task automatic finish_test(input int exp_issues, output int test_errors);
        if (exp_q.size() != 0)
            note_failure($sformatf("%0d instructions never issued", exp_q.size()));
        compare("issue count", exp_issues, issues);
        test_errors = errors;
    endtask

    // One issue against the head of the expected list
    task automatic check_issue();
        instr_t w;
        issues++;
        if (exp_q.size() == 0) begin
            note_failure("issue with no instruction left in the program");
            return;
        end
        w = exp_q.pop_front();
        compare("opcode", w[15:11], issue_opcode);
        compare("strobes", ref_strobes(w), strobes);
        compare("vpu_start", is_vector(w), vpu_start);
        if (vec_pending && !rdy_seen)
            note_failure("issue before vpu_rdy was seen high after a vector instruction");
        if (wait_pending && (cycle - wait_cycle < wait_len))
            note_failure($sformatf("issue %0d cycles after a WAIT that needs %0d",
                                   cycle - wait_cycle, wait_len));
        if (w[15:11] == `CPU_OP_HALT) begin
            compare("halt", 1'b1, halt);
            halted = 1'b1;
        end
        vec_pending  = is_vector(w);
        rdy_seen     = 1'b0;
        wait_pending = (w[15:11] == `CPU_OP_NOP) && (w[10:0] != '0);
        wait_cycle   = cycle;
        wait_len     = int'(w[10:0]) * `CPU_TICK_CYCLES;
    endtask

    //////////////////////////////
    // Per-cycle monitor
    //////////////////////////////
    always @(posedge clk) begin
        cycle++;
        if (!rst_n) begin
            halted       = 1'b0;
            vec_pending  = 1'b0;
            wait_pending = 1'b0;
        end else begin
            if (vpu_start && !issue)
                note_failure("vpu_start pulsed without an issue");
            if (halted && issue)
                note_failure("instruction issued after HALT");
            if (halted && !halt)
                note_failure("halt dropped before reset");
            if (halted && !stall)
                note_failure("stall low while halted");
            if (wait_pending && !issue && (cycle - wait_cycle < wait_len) && !stall)
                note_failure("stall low while a WAIT is running");
            if (vec_pending && !rdy_seen && !issue && !vpu_rdy && !stall)
                note_failure("stall low while the vector unit is busy");
            if (issue)
                check_issue();
            else if (vec_pending && vpu_rdy)
                rdy_seen = 1'b1;    // Vector unit free again
        end
    end

endmodule

// File: dv/cpu_ctrl_tb.sv
// CPU control path testbench
`timescale 1ns/1ps
`include "cpu_ctrl_consts.svh"

module cpu_ctrl_tb;
    import cpu_ctrl_pkg::*;

    logic       clk = 1'b0;
    logic       rst_n, prog_we, start, vpu_rdy;
    imem_addr_t prog_addr;
    instr_t     prog_data;
    opcode_t    issue_opcode;
    logic       issue, vpu_start, halt, stall, fetch_busy;
    logic       alu_to_reg, pcr_to_reg, mem_to_reg, reg_we_dst_0, reg_we_dst_1;
    logic       reg_read_0, reg_read_1, mem_we, mem_re, add_immd, jump_immd;
    logic       ldu, ldl, branch, jump, z_we, n_we, v_we;

    integer     seed = 32'he77b;        // Program stream
    integer     vpu_seed = 32'he77b;    // vpu_rdy stream
    instr_t     prog[$];                // Current program image
    int         cycle_cnt = 0;
    int         cycle_limit = 200;      // Grows as tests are built
    int         pass_cnt = 0;
    int         fail_cnt = 0;

    cpu_ctrl_top cpu_ctrl_top_i (.*);

    cpu_ctrl_checker chk (
        .clk, .rst_n, .issue, .issue_opcode,
        .strobes ({alu_to_reg, pcr_to_reg, mem_to_reg, reg_we_dst_0, reg_we_dst_1,
                   reg_read_0, reg_read_1, mem_we, mem_re, add_immd, jump_immd,
                   ldu, ldl, branch, jump, z_we, n_we, v_we}),
        .vpu_start, .halt, .stall, .vpu_rdy
    );

    always #2 clk = ~clk;   // 4 ns period

    // Vector unit model, busy about half the time
    always @(posedge clk) vpu_rdy <= 1'($random(vpu_seed) & 1);

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: no HALT seen within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Word builders
    //////////////////////////////
    function automatic int pick(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic instr_t scalar_word(opcode_t op, logic x);
        wait_t low;
        low     = wait_t'($random(seed));
        low[10] = x;
        if (op == `CPU_OP_NOP) low = x ? 11'h400 : '0;  // x set makes a long WAIT
        return {op, low};
    endfunction

    function automatic instr_t random_scalar();
        return scalar_word(opcode_t'(pick(0, 14)), 1'(pick(0, 1)));
    endfunction

    function automatic instr_t wait_word(int ticks);
        return {`CPU_OP_NOP, wait_t'(ticks)};
    endfunction

    function automatic instr_t vector_word();
        return {opcode_t'(pick(16, 30)), wait_t'($random(seed))};
    endfunction

    //////////////////////////////
    // Test sequencing
    //////////////////////////////
    task automatic reset_dut();
        @(posedge clk);
        rst_n   <= 1'b0;
        prog_we <= 1'b0;
        start   <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= imem_addr_t'(i);
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        start   <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic run_program(input string name);
        int   n_exp;
        int   max_wait;
        int   errs;
        logic past_halt;
        n_exp     = 0;
        max_wait  = 0;
        past_halt = 1'b0;
        reset_dut();
        @(negedge clk);
        chk.begin_test(name);
        foreach (prog[i]) begin
            if (!past_halt) begin   // Words after HALT never issue
                chk.expect_word(prog[i]);
                n_exp++;
                if (prog[i][15:11] == `CPU_OP_NOP && int'(prog[i][10:0]) > max_wait)
                    max_wait = int'(prog[i][10:0]);
                past_halt = (prog[i][15:11] == `CPU_OP_HALT);
            end
        end
        cycle_limit += prog.size() * (max_wait * `CPU_TICK_CYCLES + 20);
        load_program();
        do @(negedge clk); while (!halt);
        repeat (50) @(negedge clk);     // Checker watches for late issues
        if (fetch_busy) chk.note_failure("fetch stage still busy after HALT");
        chk.finish_test(n_exp, errs);
        if (errs == 0) pass_cnt++;
        else           fail_cnt++;
        $display("%-12s %s, %0d words issued, %0d errors",
                 name, (errs == 0) ? "passed" : "failed", n_exp, errs);
    endtask

    initial begin
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        start     = 1'b0;
        vpu_rdy   = 1'b0;

        // Every scalar opcode with both x values
        prog.delete();
        for (int op = 0; op < 16; op++) begin
            prog.push_back(scalar_word(opcode_t'(op), 1'b0));
            prog.push_back(scalar_word(opcode_t'(op), 1'b1));
        end
        prog.push_back({`CPU_OP_HALT, 11'd0});
        run_program("decode_all");

        // WAITs of 1 to 7 ticks, then a plain NOP
        prog.delete();
        for (int i = 1; i <= 7; i++) begin
            prog.push_back(wait_word(i));
            prog.push_back(random_scalar());
        end
        prog.push_back(wait_word(0));
        prog.push_back({`CPU_OP_HALT, 11'd0});
        run_program("wait_stall");

        prog.delete();
        for (int i = 0; i < 23; i++)
            prog.push_back(pick(0, 1) ? vector_word() : random_scalar());
        prog.push_back({`CPU_OP_HALT, 11'd0});
        run_program("vector");

        // Mixed programs that fill the queue
        for (int t = 0; t < 4; t++) begin
            int len;
            len = pick(30, 60);
            prog.delete();
            for (int i = 0; i < len - 1; i++) begin
                case (pick(0, 3))
                    0:       prog.push_back(wait_word(pick(1, 7)));
                    1:       prog.push_back(vector_word());
                    default: prog.push_back(random_scalar());
                endcase
            end
            prog.push_back({`CPU_OP_HALT, 11'd0});
            run_program($sformatf("backpress_%0d", t));
        end

        // Words after HALT stay unfetched
        prog.delete();
        for (int i = 0; i < 10; i++) prog.push_back(random_scalar());
        prog.push_back({`CPU_OP_HALT, 11'd0});
        for (int i = 0; i < 5; i++)
            prog.push_back(pick(0, 1) ? vector_word() : random_scalar());
        run_program("halt_tail");

        $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: all.f
+incdir+hw
hw/cpu_ctrl_pkg.sv
hw/wait_timer.sv
hw/instr_fetch.sv
hw/instr_queue.sv
hw/control_unit.sv
hw/cpu_ctrl_top.sv
dv/cpu_ctrl_checker.sv
dv/cpu_ctrl_tb.sv

// File: Bender.yml
package:
  name: cpu_ctrl

sources:
  # RTL
  - include_dirs:
      - hw
    files:
      - hw/cpu_ctrl_pkg.sv
      - hw/wait_timer.sv
      - hw/instr_fetch.sv
      - hw/instr_queue.sv
      - hw/control_unit.sv
      - hw/cpu_ctrl_top.sv

  # Testbench
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/cpu_ctrl_checker.sv
      - dv/cpu_ctrl_tb.sv
